/* design/eth_tx_pkg.sv */
package eth_tx_pkg;

	////////////////////////////////////////////////////////////
	// Field widths

	typedef logic [47:0] mac_addr_t;
	typedef logic [15:0] ethertype_t;

	// Payload length in bytes, sized for jumbo frames
	typedef logic [13:0] frame_len_t;

	// First byte on the wire sits in bits 31:24
	typedef logic [31:0] payload_word_t;

	// Valid bytes in one input word, 1 to 4
	typedef logic [2:0] word_bytes_t;

	typedef logic [7:0] tx_byte_t;

	////////////////////////////////////////////////////////////
	// State and byte select encodings

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_HEADER,
		SEQ_PAYLOAD,
		SEQ_POP
	} seq_state_t;

	typedef enum logic [1:0] {
		SRC_DST_MAC,
		SRC_SRC_MAC,
		SRC_ETHERTYPE,
		SRC_PAYLOAD
	} byte_src_t;

	// Free payload words needed before a new packet is admitted
	localparam int MIN_FRAME_WORDS = 8;

	// Destination MAC, source MAC and ethertype
	localparam int HEADER_BYTES = 14;

endpackage

/* design/tx_admit.sv */
module tx_admit #(
	parameter int PACKET_DEPTH = 1024,
	localparam int PTR_W = $clog2(PACKET_DEPTH)
) (
	input  logic                     mac_tx_clk,
	input  logic                     rst_n,
	input  logic                     l2_start,
	input  logic                     l2_data_valid,
	input  eth_tx_pkg::payload_word_t l2_data,
	input  eth_tx_pkg::word_bytes_t  l2_bytes_valid,
	input  logic                     l2_commit,
	input  logic                     l2_drop,
	input  eth_tx_pkg::mac_addr_t    l2_dst_mac,
	input  eth_tx_pkg::ethertype_t   l2_ethertype,
	input  logic [PTR_W:0]           free_words,
	input  logic                     hdr_full,
	output logic                     wr_en,
	output eth_tx_pkg::payload_word_t wr_data,
	output logic                     commit,
	output logic                     rollback,
	output logic                     hdr_push,
	output eth_tx_pkg::mac_addr_t    hdr_dst_mac,
	output eth_tx_pkg::ethertype_t   hdr_ethertype,
	output eth_tx_pkg::frame_len_t   hdr_len
);

	logic                   packet_active;
	logic                   start_ok;
	logic                   data_room;
	eth_tx_pkg::frame_len_t len_acc;
	eth_tx_pkg::mac_addr_t  dst_mac_q;
	eth_tx_pkg::ethertype_t ethertype_q;

	////////////////////////////////////////////////////////////
	// Admission and overflow rules

	// Need one header slot plus a minimum frame worth of payload space
	assign start_ok = !packet_active && l2_start && !hdr_full &&
		(free_words >= (PTR_W + 1)'(eth_tx_pkg::MIN_FRAME_WORDS));

	// Last free word is never filled, running out aborts the packet
	assign data_room = (free_words > (PTR_W + 1)'(1));

	// Commit beats drop, drop beats data
	assign commit   = packet_active && l2_commit;
	assign rollback = packet_active && !l2_commit &&
		(l2_drop || (l2_data_valid && !data_room));
	assign wr_en    = packet_active && !l2_commit && !l2_drop &&
		l2_data_valid && data_room;
	assign wr_data  = l2_data;

	// Header entry goes in with the payload commit
	assign hdr_push      = commit;
	assign hdr_dst_mac   = dst_mac_q;
	assign hdr_ethertype = ethertype_q;
	assign hdr_len       = len_acc;

	////////////////////////////////////////////////////////////
	// Packet state

	always_ff @(posedge mac_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			packet_active <= 1'b0;
			len_acc       <= '0;
		end else begin
			if (start_ok) begin
				packet_active <= 1'b1;
				len_acc       <= '0;
			end else if (commit || rollback) begin
				packet_active <= 1'b0;
			end
			if (wr_en)
				len_acc <= len_acc + eth_tx_pkg::frame_len_t'(l2_bytes_valid);
		end
	end

	// Addressing is sampled with the start strobe
	always_ff @(posedge mac_tx_clk) begin
		if (start_ok) begin
			dst_mac_q   <= l2_dst_mac;
			ethertype_q <= l2_ethertype;
		end
	end

	// A write never leaves the payload buffer without a free word
	a_no_write_when_full: assert property (
		@(posedge mac_tx_clk) disable iff (!rst_n)
		wr_en |=> (free_words != '0)
	);

endmodule

/* design/payload_buffer.sv */
module payload_buffer #(
	parameter int PACKET_DEPTH = 1024,
	localparam int PTR_W = $clog2(PACKET_DEPTH)
) (
	input  logic                      mac_tx_clk,
	input  logic                      rst_n,
	input  logic                      wr_en,
	input  eth_tx_pkg::payload_word_t wr_data,
	input  logic                      commit,
	input  logic                      rollback,
	input  logic                      rd_en,
	input  logic [PTR_W-1:0]          rd_offset,
	input  logic                      pop_packet,
	input  logic [PTR_W:0]            pop_words,
	output logic [PTR_W:0]            free_words,
	output logic                      packet_ready,
	output eth_tx_pkg::payload_word_t rd_data
);

	// Pointers carry one extra wrap bit so full and empty differ
	logic [PTR_W:0] wr_pend;
	logic [PTR_W:0] wr_commit;
	logic [PTR_W:0] rd_head;
	logic [PTR_W-1:0] rd_addr;

	eth_tx_pkg::payload_word_t mem [PACKET_DEPTH];

	////////////////////////////////////////////////////////////
	// Occupancy

	// Pending words count against free space too
	assign free_words   = (PTR_W + 1)'(PACKET_DEPTH) - (wr_pend - rd_head);
	assign packet_ready = (wr_commit != rd_head);

	////////////////////////////////////////////////////////////
	// Pointer update

	always_ff @(posedge mac_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_pend   <= '0;
			wr_commit <= '0;
			rd_head   <= '0;
		end else begin
			// Rollback rewinds to the last committed packet
			if (rollback)
				wr_pend <= wr_commit;
			else if (wr_en)
				wr_pend <= wr_pend + 1'b1;
			if (commit)
				wr_commit <= wr_pend;
			if (pop_packet)
				rd_head <= rd_head + pop_words;
		end
	end

	////////////////////////////////////////////////////////////
	// Word memory

	// Reads are relative to the start of the head packet
	assign rd_addr = rd_head[PTR_W-1:0] + rd_offset;

	always_ff @(posedge mac_tx_clk) begin
		if (wr_en)
			mem[wr_pend[PTR_W-1:0]] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

/* design/header_queue.sv */
module header_queue #(
	parameter int HEADER_DEPTH = 16,
	localparam int HQ_W = $clog2(HEADER_DEPTH)
) (
	input  logic                   mac_tx_clk,
	input  logic                   rst_n,
	input  logic                   push,
	input  eth_tx_pkg::mac_addr_t  push_dst_mac,
	input  eth_tx_pkg::ethertype_t push_ethertype,
	input  eth_tx_pkg::frame_len_t push_len,
	input  logic                   pop,
	output logic                   full,
	output logic                   not_empty,
	output eth_tx_pkg::mac_addr_t  head_dst_mac,
	output eth_tx_pkg::ethertype_t head_ethertype,
	output eth_tx_pkg::frame_len_t head_len
);

	logic [HQ_W-1:0] wr_ptr;
	logic [HQ_W-1:0] rd_ptr;
	logic [HQ_W:0]   count;

	eth_tx_pkg::mac_addr_t  dst_mem [HEADER_DEPTH];
	eth_tx_pkg::ethertype_t type_mem [HEADER_DEPTH];
	eth_tx_pkg::frame_len_t len_mem [HEADER_DEPTH];

	assign full      = (count == (HQ_W + 1)'(HEADER_DEPTH));
	assign not_empty = (count != '0);

	// Show-ahead head entry
	assign head_dst_mac   = dst_mem[rd_ptr];
	assign head_ethertype = type_mem[rd_ptr];
	assign head_len       = len_mem[rd_ptr];

	always_ff @(posedge mac_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
		end
	end

	always_ff @(posedge mac_tx_clk) begin
		if (push) begin
			dst_mem[wr_ptr]  <= push_dst_mac;
			type_mem[wr_ptr] <= push_ethertype;
			len_mem[wr_ptr]  <= push_len;
		end
	end

	// Admission upstream and the sequencer downstream keep the queue in range
	a_no_overrun: assert property (
		@(posedge mac_tx_clk) disable iff (!rst_n)
		!(push && full) && !(pop && !not_empty)
	);

endmodule

/* design/frame_sequencer.sv */
module frame_sequencer #(
	parameter int PACKET_DEPTH = 1024,
	localparam int PTR_W = $clog2(PACKET_DEPTH)
) (
	input  logic                   mac_tx_clk,
	input  logic                   rst_n,
	input  logic                   mac_tx_ready,
	input  logic                   not_empty,
	input  logic                   packet_ready,
	input  eth_tx_pkg::frame_len_t head_len,
	output logic                   hdr_pop,
	output logic                   load_header,
	output logic                   rd_en,
	output logic [PTR_W-1:0]       rd_offset,
	output logic                   word_load,
	output logic                   pop_packet,
	output logic [PTR_W:0]         pop_words,
	output logic                   emit,
	output logic                   frame_start,
	output eth_tx_pkg::byte_src_t  byte_src,
	output logic [2:0]             byte_index
);

	eth_tx_pkg::seq_state_t state;
	eth_tx_pkg::frame_len_t len_q;
	eth_tx_pkg::frame_len_t pos;
	eth_tx_pkg::frame_len_t end_pos;
	logic                   take;

	////////////////////////////////////////////////////////////
	// Frame position bookkeeping

	// pos counts wire bytes from the first destination MAC byte
	assign end_pos = eth_tx_pkg::frame_len_t'(eth_tx_pkg::HEADER_BYTES) + len_q;

	// Header, payload and MAC must all be ready
	assign take = (state == eth_tx_pkg::SEQ_IDLE) && not_empty && packet_ready &&
		mac_tx_ready;
	assign hdr_pop     = take;
	assign load_header = take;

	assign emit        = (state == eth_tx_pkg::SEQ_HEADER) ||
		(state == eth_tx_pkg::SEQ_PAYLOAD);
	assign frame_start = (state == eth_tx_pkg::SEQ_HEADER) && (pos == '0);

	// Fetch a word two bytes ahead of its first byte, the first one at header byte 12
	assign rd_en = emit && (pos[1:0] == 2'd0) &&
		(pos >= eth_tx_pkg::frame_len_t'(eth_tx_pkg::HEADER_BYTES - 2)) &&
		((pos + eth_tx_pkg::frame_len_t'(2)) < end_pos);

	// Round the length up to whole words
	assign pop_packet = (state == eth_tx_pkg::SEQ_POP);
	assign pop_words  = (PTR_W + 1)'(len_q[13:2] + {11'd0, |len_q[1:0]});

	////////////////////////////////////////////////////////////
	// Byte select

	always_comb begin
		byte_src   = eth_tx_pkg::SRC_PAYLOAD;
		byte_index = {1'b0, pos[1:0] + 2'd2};
		if (state == eth_tx_pkg::SEQ_HEADER) begin
			if (pos < eth_tx_pkg::frame_len_t'(6)) begin
				byte_src   = eth_tx_pkg::SRC_DST_MAC;
				byte_index = pos[2:0];
			end else if (pos < eth_tx_pkg::frame_len_t'(12)) begin
				byte_src   = eth_tx_pkg::SRC_SRC_MAC;
				byte_index = 3'(pos - eth_tx_pkg::frame_len_t'(6));
			end else begin
				byte_src   = eth_tx_pkg::SRC_ETHERTYPE;
				byte_index = 3'(pos - eth_tx_pkg::frame_len_t'(12));
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Sequencer FSM

	always_ff @(posedge mac_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= eth_tx_pkg::SEQ_IDLE;
			len_q     <= '0;
			pos       <= '0;
			rd_offset <= '0;
			word_load <= 1'b0;
		end else begin
			// Serializer picks up read data the cycle after the read
			word_load <= rd_en;
			if (rd_en)
				rd_offset <= rd_offset + 1'b1;
			unique case (state)
				eth_tx_pkg::SEQ_IDLE: begin
					if (take) begin
						len_q     <= head_len;
						pos       <= '0;
						rd_offset <= '0;
						state     <= eth_tx_pkg::SEQ_HEADER;
					end
				end
				eth_tx_pkg::SEQ_HEADER: begin
					pos <= pos + 1'b1;
					if (pos == eth_tx_pkg::frame_len_t'(eth_tx_pkg::HEADER_BYTES - 1))
						state <= (len_q == '0) ? eth_tx_pkg::SEQ_POP : eth_tx_pkg::SEQ_PAYLOAD;
				end
				eth_tx_pkg::SEQ_PAYLOAD: begin
					pos <= pos + 1'b1;
					if (pos == end_pos - 1'b1)
						state <= eth_tx_pkg::SEQ_POP;
				end
				// Release the payload words, leaves a gap between frames
				eth_tx_pkg::SEQ_POP: state <= eth_tx_pkg::SEQ_IDLE;
				default: state <= eth_tx_pkg::SEQ_IDLE;
			endcase
		end
	end

	// A frame only begins right after a take with the MAC ready
	a_start_from_idle: assert property (
		@(posedge mac_tx_clk) disable iff (!rst_n)
		frame_start |-> $past(state == eth_tx_pkg::SEQ_IDLE && mac_tx_ready)
	);

endmodule

/* design/tx_byte_serializer.sv */
module tx_byte_serializer (
	input  logic                      mac_tx_clk,
	input  logic                      rst_n,
	input  eth_tx_pkg::mac_addr_t     our_mac_address,
	input  logic                      load_header,
	input  eth_tx_pkg::mac_addr_t     head_dst_mac,
	input  eth_tx_pkg::ethertype_t    head_ethertype,
	input  logic                      word_load,
	input  eth_tx_pkg::payload_word_t rd_data,
	input  logic                      emit,
	input  logic                      frame_start,
	input  eth_tx_pkg::byte_src_t     byte_src,
	input  logic [2:0]                byte_index,
	output logic                      mac_tx_start,
	output logic                      mac_tx_valid,
	output eth_tx_pkg::tx_byte_t      mac_tx_data
);

	eth_tx_pkg::mac_addr_t     dst_mac_q;
	eth_tx_pkg::ethertype_t    ethertype_q;
	eth_tx_pkg::payload_word_t word_q;
	eth_tx_pkg::tx_byte_t      sel_byte;

	////////////////////////////////////////////////////////////
	// Held header fields and current payload word

	always_ff @(posedge mac_tx_clk) begin
		if (load_header) begin
			dst_mac_q   <= head_dst_mac;
			ethertype_q <= head_ethertype;
		end
		if (word_load)
			word_q <= rd_data;
	end

	// Index 0 is always the most significant byte
	always_comb begin
		unique case (byte_src)
			eth_tx_pkg::SRC_DST_MAC:   sel_byte = dst_mac_q[8 * (5 - byte_index) +: 8];
			eth_tx_pkg::SRC_SRC_MAC:   sel_byte = our_mac_address[8 * (5 - byte_index) +: 8];
			eth_tx_pkg::SRC_ETHERTYPE: sel_byte = ethertype_q[8 * (1 - byte_index[0]) +: 8];
			default:                   sel_byte = word_q[8 * (3 - byte_index[1:0]) +: 8];
		endcase
	end

	////////////////////////////////////////////////////////////
	// MAC output registers

	always_ff @(posedge mac_tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			mac_tx_start <= 1'b0;
			mac_tx_valid <= 1'b0;
			mac_tx_data  <= '0;
		end else begin
			mac_tx_start <= frame_start;
			mac_tx_valid <= emit;
			// Data bus is zero between frames
			mac_tx_data  <= emit ? sel_byte : '0;
		end
	end

endmodule

/* design/eth_tx_buffer.sv */
module eth_tx_buffer #(
	parameter int PACKET_DEPTH = 1024,
	parameter int HEADER_DEPTH = 16
) (
	input  logic                      mac_tx_clk,
	input  logic                      rst_n,
	input  eth_tx_pkg::mac_addr_t     our_mac_address,
	input  logic                      l2_start,
	input  logic                      l2_data_valid,
	input  eth_tx_pkg::payload_word_t l2_data,
	input  eth_tx_pkg::word_bytes_t   l2_bytes_valid,
	input  logic                      l2_commit,
	input  logic                      l2_drop,
	input  eth_tx_pkg::mac_addr_t     l2_dst_mac,
	input  eth_tx_pkg::ethertype_t    l2_ethertype,
	input  logic                      mac_tx_ready,
	output logic                      mac_tx_start,
	output logic                      mac_tx_valid,
	output eth_tx_pkg::tx_byte_t      mac_tx_data
);

	localparam int PTR_W = $clog2(PACKET_DEPTH);

	// Write side
	logic                      wr_en;
	eth_tx_pkg::payload_word_t wr_data;
	logic                      commit;
	logic                      rollback;
	logic [PTR_W:0]            free_words;
	logic                      hdr_push;
	logic                      hdr_full;
	eth_tx_pkg::mac_addr_t     hdr_dst_mac;
	eth_tx_pkg::ethertype_t    hdr_ethertype;
	eth_tx_pkg::frame_len_t    hdr_len;

	// Read side
	logic                      not_empty;
	logic                      hdr_pop;
	eth_tx_pkg::mac_addr_t     head_dst_mac;
	eth_tx_pkg::ethertype_t    head_ethertype;
	eth_tx_pkg::frame_len_t    head_len;
	logic                      packet_ready;
	logic                      rd_en;
	logic [PTR_W-1:0]          rd_offset;
	eth_tx_pkg::payload_word_t rd_data;
	logic                      pop_packet;
	logic [PTR_W:0]            pop_words;

	// Sequencer to serializer
	logic                      load_header;
	logic                      word_load;
	logic                      emit;
	logic                      frame_start;
	eth_tx_pkg::byte_src_t     byte_src;
	logic [2:0]                byte_index;

	////////////////////////////////////////////////////////////
	// Write path

	tx_admit #(.PACKET_DEPTH(PACKET_DEPTH)) u_admit (
		.mac_tx_clk(mac_tx_clk), .rst_n(rst_n),
		.l2_start(l2_start), .l2_data_valid(l2_data_valid), .l2_data(l2_data),
		.l2_bytes_valid(l2_bytes_valid), .l2_commit(l2_commit), .l2_drop(l2_drop),
		.l2_dst_mac(l2_dst_mac), .l2_ethertype(l2_ethertype),
		.free_words(free_words), .hdr_full(hdr_full),
		.wr_en(wr_en), .wr_data(wr_data), .commit(commit), .rollback(rollback),
		.hdr_push(hdr_push), .hdr_dst_mac(hdr_dst_mac),
		.hdr_ethertype(hdr_ethertype), .hdr_len(hdr_len)
	);

	payload_buffer #(.PACKET_DEPTH(PACKET_DEPTH)) u_payload (
		.mac_tx_clk(mac_tx_clk), .rst_n(rst_n),
		.wr_en(wr_en), .wr_data(wr_data), .commit(commit), .rollback(rollback),
		.rd_en(rd_en), .rd_offset(rd_offset),
		.pop_packet(pop_packet), .pop_words(pop_words),
		.free_words(free_words), .packet_ready(packet_ready), .rd_data(rd_data)
	);

	header_queue #(.HEADER_DEPTH(HEADER_DEPTH)) u_headers (
		.mac_tx_clk(mac_tx_clk), .rst_n(rst_n),
		.push(hdr_push), .push_dst_mac(hdr_dst_mac),
		.push_ethertype(hdr_ethertype), .push_len(hdr_len), .pop(hdr_pop),
		.full(hdr_full), .not_empty(not_empty), .head_dst_mac(head_dst_mac),
		.head_ethertype(head_ethertype), .head_len(head_len)
	);

	////////////////////////////////////////////////////////////
	// Read path

	frame_sequencer #(.PACKET_DEPTH(PACKET_DEPTH)) u_sequencer (
		.mac_tx_clk(mac_tx_clk), .rst_n(rst_n), .mac_tx_ready(mac_tx_ready),
		.not_empty(not_empty), .packet_ready(packet_ready), .head_len(head_len),
		.hdr_pop(hdr_pop), .load_header(load_header),
		.rd_en(rd_en), .rd_offset(rd_offset), .word_load(word_load),
		.pop_packet(pop_packet), .pop_words(pop_words),
		.emit(emit), .frame_start(frame_start),
		.byte_src(byte_src), .byte_index(byte_index)
	);

	tx_byte_serializer u_serializer (
		.mac_tx_clk(mac_tx_clk), .rst_n(rst_n), .our_mac_address(our_mac_address),
		.load_header(load_header), .head_dst_mac(head_dst_mac),
		.head_ethertype(head_ethertype), .word_load(word_load), .rd_data(rd_data),
		.emit(emit), .frame_start(frame_start),
		.byte_src(byte_src), .byte_index(byte_index),
		.mac_tx_start(mac_tx_start), .mac_tx_valid(mac_tx_valid),
		.mac_tx_data(mac_tx_data)
	);

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic mac_tx_clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		mac_tx_clk = 1'b0;
		forever #(PERIOD_NS / 2) mac_tx_clk = ~mac_tx_clk;
	end

	// Release lands after the edge so every flop still sees reset on it
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge mac_tx_clk);
		rst_n <= 1'b1;
	end

endmodule

/* verification/tb_eth_tx_buffer.sv */
module tb_eth_tx_buffer;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PACKET_DEPTH = 32;
	localparam int HEADER_DEPTH = 4;
	localparam int MAX_WORDS    = 32;
	localparam eth_tx_pkg::mac_addr_t OUR_MAC = 48'h02_1a_2b_3c_4d_5e;

	logic                      mac_tx_clk;
	logic                      rst_n;
	eth_tx_pkg::mac_addr_t     our_mac_address;
	logic                      l2_start;
	logic                      l2_data_valid;
	eth_tx_pkg::payload_word_t l2_data;
	eth_tx_pkg::word_bytes_t   l2_bytes_valid;
	logic                      l2_commit;
	logic                      l2_drop;
	eth_tx_pkg::mac_addr_t     l2_dst_mac;
	eth_tx_pkg::ethertype_t    l2_ethertype;
	logic                      mac_tx_ready;
	logic                      mac_tx_start;
	logic                      mac_tx_valid;
	eth_tx_pkg::tx_byte_t      mac_tx_data;

	// Reference model state
	logic [31:0]               rng;
	int                        model_words;
	int                        model_hdrs;
	int                        cycle_budget;
	logic                      in_frame;
	eth_tx_pkg::tx_byte_t      exp_bytes [$];
	eth_tx_pkg::frame_len_t    exp_lens [$];
	eth_tx_pkg::payload_word_t pkt_words [MAX_WORDS];

	tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(3)) u_clock (
		.mac_tx_clk(mac_tx_clk), .rst_n(rst_n)
	);

	eth_tx_buffer #(.PACKET_DEPTH(PACKET_DEPTH), .HEADER_DEPTH(HEADER_DEPTH)) u_dut (
		.mac_tx_clk(mac_tx_clk), .rst_n(rst_n), .our_mac_address(our_mac_address),
		.l2_start(l2_start), .l2_data_valid(l2_data_valid), .l2_data(l2_data),
		.l2_bytes_valid(l2_bytes_valid), .l2_commit(l2_commit), .l2_drop(l2_drop),
		.l2_dst_mac(l2_dst_mac), .l2_ethertype(l2_ethertype), .mac_tx_ready(mac_tx_ready),
		.mac_tx_start(mac_tx_start), .mac_tx_valid(mac_tx_valid), .mac_tx_data(mac_tx_data)
	);

	////////////////////////////////////////////////////////////
	// Helpers and reference model

	// xorshift32 step on the shared generator
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Wire order: destination MAC, our MAC, ethertype, payload high byte first
	function automatic void build_frame(input eth_tx_pkg::mac_addr_t dst,
		input eth_tx_pkg::ethertype_t etype,
		input eth_tx_pkg::payload_word_t words [MAX_WORDS], input int n_bytes);
		int k;
		for (k = 0; k < 6; k++)
			exp_bytes.push_back(dst[8 * (5 - k) +: 8]);
		for (k = 0; k < 6; k++)
			exp_bytes.push_back(OUR_MAC[8 * (5 - k) +: 8]);
		exp_bytes.push_back(etype[15:8]);
		exp_bytes.push_back(etype[7:0]);
		for (k = 0; k < n_bytes; k++)
			exp_bytes.push_back(words[k / 4][8 * (3 - k % 4) +: 8]);
		exp_lens.push_back(eth_tx_pkg::frame_len_t'(n_bytes));
	endfunction

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_byte(input eth_tx_pkg::tx_byte_t exp, input eth_tx_pkg::tx_byte_t got);
		if (got !== exp)
			report_fail($sformatf("ERROR mac_tx_data expected 0x%02h got 0x%02h", exp, got));
	endtask

	task automatic check_len(input eth_tx_pkg::frame_len_t exp, input eth_tx_pkg::frame_len_t got);
		if (got !== exp)
			report_fail($sformatf("ERROR mac_tx_valid payload length expected 0x%0h got 0x%0h",
				exp, got));
	endtask

	// Start only on the first byte, and always with valid
	task automatic check_start(input logic exp, input logic got, input logic got_valid);
		if (got !== exp)
			report_fail($sformatf("ERROR mac_tx_start expected 0x%0h got 0x%0h", exp, got));
		else if (got && got_valid !== 1'b1)
			report_fail($sformatf("ERROR mac_tx_valid expected 0x1 got 0x%0h", got_valid));
	endtask

	// Drives one packet and predicts from the admission rules whether it goes out
	task automatic send_packet(input int n_bytes, input logic do_commit);
		int n_words;
		int pending;
		int i;
		logic admitted;
		logic overflow;
		eth_tx_pkg::mac_addr_t dst;
		eth_tx_pkg::ethertype_t etype;
		n_words = (n_bytes + 3) / 4;
		dst = eth_tx_pkg::mac_addr_t'({next_rand(), next_rand()});
		etype = eth_tx_pkg::ethertype_t'(next_rand());
		for (i = 0; i < n_words; i++)
			pkt_words[i] = next_rand();
		cycle_budget += n_bytes + n_words + 60;
		admitted = (model_hdrs < HEADER_DEPTH) &&
			(PACKET_DEPTH - model_words >= eth_tx_pkg::MIN_FRAME_WORDS);
		overflow = 1'b0;
		pending = 0;
		@(posedge mac_tx_clk);
		l2_start     <= 1'b1;
		l2_dst_mac   <= dst;
		l2_ethertype <= etype;
		@(posedge mac_tx_clk);
		l2_start <= 1'b0;
		for (i = 0; i < n_words; i++) begin
			// Last free word stays empty, a word that needs it aborts the packet
			if (admitted && !overflow) begin
				if (PACKET_DEPTH - model_words - pending > 1)
					pending++;
				else
					overflow = 1'b1;
			end
			l2_data_valid  <= 1'b1;
			l2_data        <= pkt_words[i];
			l2_bytes_valid <= eth_tx_pkg::word_bytes_t'((i == n_words - 1) ? n_bytes - 4 * i : 4);
			@(posedge mac_tx_clk);
		end
		l2_data_valid <= 1'b0;
		l2_commit     <= do_commit;
		l2_drop       <= !do_commit;
		@(posedge mac_tx_clk);
		l2_commit <= 1'b0;
		l2_drop   <= 1'b0;
		if (admitted && !overflow && do_commit) begin
			model_words += pending;
			model_hdrs += 1;
			build_frame(dst, etype, pkt_words, n_bytes);
		end
	endtask

	// Model space only comes back late, so room here means room in the DUT
	task automatic wait_for_room(input int n_words);
		while (model_hdrs >= HEADER_DEPTH ||
			PACKET_DEPTH - model_words < eth_tx_pkg::MIN_FRAME_WORDS ||
			PACKET_DEPTH - model_words <= n_words)
			@(posedge mac_tx_clk);
	endtask

	task automatic wait_drain();
		while (exp_lens.size() != 0 || in_frame)
			@(posedge mac_tx_clk);
		repeat (4) @(posedge mac_tx_clk);
	endtask

	task automatic set_ready(input logic level);
		@(posedge mac_tx_clk);
		mac_tx_ready <= level;
	endtask

	////////////////////////////////////////////////////////////
	// Frame monitor and compare

	initial begin : monitor
		eth_tx_pkg::frame_len_t cur_len;
		int got;
		int ready_low;
		in_frame = 1'b0;
		cur_len = '0;
		got = 0;
		ready_low = 0;
		forever begin
			@(posedge mac_tx_clk);
			ready_low = mac_tx_ready ? 0 : ready_low + 1;
			if (rst_n && !in_frame) begin
				// The take happens two cycles before the first byte shows up
				if ((mac_tx_start || mac_tx_valid) && ready_low > 2)
					report_fail("a frame began while mac_tx_ready was held low");
				else if ((mac_tx_start || mac_tx_valid) && exp_lens.size() == 0)
					report_fail("a frame started that the reference model does not expect");
				else if (mac_tx_start || mac_tx_valid) begin
					check_start(1'b1, mac_tx_start, mac_tx_valid);
					cur_len = exp_lens.pop_front();
					check_byte(exp_bytes.pop_front(), mac_tx_data);
					got = 1;
					in_frame = 1'b1;
				end
			end else if (rst_n && mac_tx_valid) begin
				check_start(1'b0, mac_tx_start, mac_tx_valid);
				// One byte past the end means the frame ran long
				if (got == eth_tx_pkg::HEADER_BYTES + cur_len)
					check_len(cur_len, eth_tx_pkg::frame_len_t'(got + 1 - eth_tx_pkg::HEADER_BYTES));
				else begin
					check_byte(exp_bytes.pop_front(), mac_tx_data);
					got++;
				end
			end else if (rst_n && got < eth_tx_pkg::HEADER_BYTES + cur_len)
				report_fail($sformatf("mac_tx_valid dropped inside a frame after %0d bytes", got));
			else if (rst_n) begin
				// Header slot and words of the finished frame return to the model
				model_words -= (int'(cur_len) + 3) / 4;
				model_hdrs -= 1;
				in_frame = 1'b0;
			end
		end
	end

	// Budget grows with every packet sent
	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge mac_tx_clk);
			cycles++;
			if (cycles > cycle_budget)
				report_fail($sformatf("timeout after %0d cycles waiting for frames", cycles));
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin : stimulus
		int i;
		int len;
		our_mac_address = OUR_MAC;
		l2_start        = 1'b0;
		l2_data_valid   = 1'b0;
		l2_data         = '0;
		l2_bytes_valid  = '0;
		l2_commit       = 1'b0;
		l2_drop         = 1'b0;
		l2_dst_mac      = '0;
		l2_ethertype    = '0;
		mac_tx_ready    = 1'b1;
		rng             = 32'd35;
		model_words     = 0;
		model_hdrs      = 0;
		cycle_budget    = 1000;
		@(posedge rst_n);

		// Single frame, length not a word multiple
		send_packet(13, 1'b1);
		wait_drain();

		// Random lengths back to back
		for (i = 0; i < 6; i++) begin
			len = 1 + int'(next_rand() % 28);
			wait_for_room((len + 3) / 4);
			send_packet(len, 1'b1);
		end
		wait_drain();

		// Dropped packet then a good one
		send_packet(1 + int'(next_rand() % 20), 1'b0);
		send_packet(1 + int'(next_rand() % 20), 1'b1);
		wait_drain();

		// Kept 20 words, overrun of the last 12, a 5 word packet, then a refused start
		set_ready(1'b0);
		send_packet(80, 1'b1);
		send_packet(56, 1'b1);
		send_packet(18, 1'b1);
		send_packet(10, 1'b1);
		repeat (20) @(posedge mac_tx_clk);
		set_ready(1'b1);
		wait_drain();

		// Header queue fills at four, the fifth start is refused
		set_ready(1'b0);
		for (i = 0; i < 5; i++)
			send_packet(7, 1'b1);
		repeat (20) @(posedge mac_tx_clk);
		set_ready(1'b1);
		wait_drain();

		if (exp_lens.size() != 0 || exp_bytes.size() != 0) begin
			report_fail("expected frame bytes were left over at the end of the run");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

/* tb.f */
design/eth_tx_pkg.sv
design/tx_admit.sv
design/payload_buffer.sv
design/header_queue.sv
design/frame_sequencer.sv
design/tx_byte_serializer.sv
design/eth_tx_buffer.sv
verification/tb_clock_gen.sv
verification/tb_eth_tx_buffer.sv
